//--- logic/core_ctrl_pkg.sv
// Shared widths and types of the commit control slice; XLEN is fixed at 64 and two commit ports
`default_nettype none

package core_ctrl_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int unsigned XLEN              = 64;
  localparam int unsigned NR_COMMIT_PORTS   = 2;
  localparam int unsigned CNT_WIDTH_DEFAULT = 48;
  localparam int unsigned NR_COUNTERS       = 6;

  typedef logic [XLEN-1:0]            addr_t;
  typedef logic [NR_COMMIT_PORTS-1:0] commit_ack_t;
  typedef logic [2:0]                 perf_idx_t;

  // Performance counter map
  localparam perf_idx_t CNT_INSTRET     = 3'd0;
  localparam perf_idx_t CNT_EXCEPTION   = 3'd1;
  localparam perf_idx_t CNT_ERET        = 3'd2;
  localparam perf_idx_t CNT_MISPREDICT  = 3'd3;
  localparam perf_idx_t CNT_FENCE       = 3'd4;
  localparam perf_idx_t CNT_HALT_CYCLES = 3'd5;

  // ----------------------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------------------
  // One-cycle strobes from the commit stage
  typedef struct packed {
    commit_ack_t commit_ack;
    logic        exception;
    logic        eret;
    logic        mispredict;
    logic        fence;
    logic        fence_i;
  } commit_event_t;

  // Candidate fetch addresses
  typedef struct packed {
    addr_t trap_vector;
    addr_t epc;
    addr_t branch_target;
    addr_t pc_commit;
  } redirect_ops_t;

  typedef struct packed {
    logic flush_if;
    logic flush_id;
    logic flush_ex;
    logic flush_bp;
    logic set_pc;
    logic flush_icache;
  } flush_t;

  typedef enum logic [2:0] {
    REDIR_NONE,
    REDIR_TRAP,
    REDIR_EPC,
    REDIR_BRANCH,
    REDIR_NEXT
  } redirect_src_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DCACHE_FLUSH,
    ST_RESUME
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/flush_fsm.sv
// Commit events are honoured only in idle; the dcache flush wait has no timeout
`timescale 1ns/1ps
`default_nettype none

module flush_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  core_ctrl_pkg::commit_event_t commit_i,
  input  logic                         dcache_flush_ack_i,
  output core_ctrl_pkg::flush_t        flush_o,
  output logic                         flush_dcache_o,
  output logic                         halt_o,
  output core_ctrl_pkg::redirect_src_t redirect_src_o
);

  core_ctrl_pkg::ctrl_state_t state_d, state_q;
  core_ctrl_pkg::flush_t      flush_d, flush_q;
  // Set while the pending fence is a fence.i
  logic                       fence_i_d, fence_i_q;

  // Front of pipe is always cleared together with a PC redirect
  function automatic core_ctrl_pkg::flush_t redirect_flush(input logic bp);
    core_ctrl_pkg::flush_t f;
    f          = '0;
    f.flush_if = 1'b1;
    f.flush_id = 1'b1;
    f.flush_ex = 1'b1;
    f.flush_bp = bp;
    f.set_pc   = 1'b1;
    return f;
  endfunction

  // ----------------------------------------------------------------------
  // Next state and event priority
  // ----------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    flush_d        = '0;
    fence_i_d      = fence_i_q;
    redirect_src_o = core_ctrl_pkg::REDIR_NONE;

    case (state_q)
      core_ctrl_pkg::ST_IDLE: begin
        // Exception > eret > mispredict > fence.i > fence
        if (commit_i.exception) begin
          flush_d        = redirect_flush(1'b1);
          redirect_src_o = core_ctrl_pkg::REDIR_TRAP;
        end else if (commit_i.eret) begin
          flush_d        = redirect_flush(1'b1);
          redirect_src_o = core_ctrl_pkg::REDIR_EPC;
        end else if (commit_i.mispredict) begin
          flush_d        = redirect_flush(1'b0);
          redirect_src_o = core_ctrl_pkg::REDIR_BRANCH;
        end else if (commit_i.fence_i || commit_i.fence) begin
          state_d   = core_ctrl_pkg::ST_DCACHE_FLUSH;
          fence_i_d = commit_i.fence_i;
        end
      end

      core_ctrl_pkg::ST_DCACHE_FLUSH: begin
        // Restart fetch after the fence once the dcache is clean
        if (dcache_flush_ack_i) begin
          state_d              = core_ctrl_pkg::ST_RESUME;
          flush_d              = redirect_flush(1'b0);
          flush_d.flush_icache = fence_i_q;
          redirect_src_o       = core_ctrl_pkg::REDIR_NEXT;
        end
      end

      core_ctrl_pkg::ST_RESUME: begin
        state_d   = core_ctrl_pkg::ST_IDLE;
        fence_i_d = 1'b0;
      end

      default: begin
        state_d   = core_ctrl_pkg::ST_IDLE;
        fence_i_d = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= core_ctrl_pkg::ST_IDLE;
      flush_q   <= '0;
      fence_i_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      flush_q   <= flush_d;
      fence_i_q <= fence_i_d;
    end
  end

  assign flush_o = flush_q;

  // Request and halt cover exactly the wait for the acknowledge
  assign flush_dcache_o = (state_q == core_ctrl_pkg::ST_DCACHE_FLUSH);
  assign halt_o         = (state_q == core_ctrl_pkg::ST_DCACHE_FLUSH);

endmodule

`default_nettype wire

//--- logic/redirect_unit.sv
// Redirect PC holds its last selection; the sequential step assumes 4-byte instructions
`timescale 1ns/1ps
`default_nettype none

module redirect_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  core_ctrl_pkg::redirect_src_t redirect_src_i,
  input  core_ctrl_pkg::redirect_ops_t redirect_ops_i,
  output core_ctrl_pkg::addr_t         redirect_pc_o
);

  localparam core_ctrl_pkg::addr_t PcStep = 'd4;

  core_ctrl_pkg::addr_t pc_d, pc_q;
  logic                 load;

  // Operand mux
  always_comb begin
    load = 1'b1;
    pc_d = pc_q;
    case (redirect_src_i)
      core_ctrl_pkg::REDIR_TRAP:   pc_d = redirect_ops_i.trap_vector;
      core_ctrl_pkg::REDIR_EPC:    pc_d = redirect_ops_i.epc;
      core_ctrl_pkg::REDIR_BRANCH: pc_d = redirect_ops_i.branch_target;
      // Instruction after the fence
      core_ctrl_pkg::REDIR_NEXT:   pc_d = redirect_ops_i.pc_commit + PcStep;
      default:                     load = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else if (load) begin
      pc_q <= pc_d;
    end
  end

  assign redirect_pc_o = pc_q;

endmodule

`default_nettype wire

//--- logic/event_counters.sv
// Counters wrap silently; reads of unmapped indices return zero, writes to them are dropped
`timescale 1ns/1ps
`default_nettype none

module event_counters #(
  parameter int unsigned CntWidth = core_ctrl_pkg::CNT_WIDTH_DEFAULT
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  core_ctrl_pkg::commit_event_t commit_i,
  input  logic                         halt_i,
  input  core_ctrl_pkg::perf_idx_t     perf_addr_i,
  input  logic                         perf_we_i,
  input  logic [CntWidth-1:0]          perf_wdata_i,
  output logic [CntWidth-1:0]          perf_rdata_o
);

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t cnt_q [core_ctrl_pkg::NR_COUNTERS];
  cnt_t inc   [core_ctrl_pkg::NR_COUNTERS];

  // ----------------------------------------------------------------------
  // Per-counter increments
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < core_ctrl_pkg::NR_COUNTERS; i++) begin
      inc[i] = '0;
    end
    // Up to one retire per commit port
    for (int p = 0; p < core_ctrl_pkg::NR_COMMIT_PORTS; p++) begin
      inc[core_ctrl_pkg::CNT_INSTRET] = inc[core_ctrl_pkg::CNT_INSTRET]
                                        + cnt_t'(commit_i.commit_ack[p]);
    end
    inc[core_ctrl_pkg::CNT_EXCEPTION]   = cnt_t'(commit_i.exception);
    inc[core_ctrl_pkg::CNT_ERET]        = cnt_t'(commit_i.eret);
    inc[core_ctrl_pkg::CNT_MISPREDICT]  = cnt_t'(commit_i.mispredict);
    inc[core_ctrl_pkg::CNT_FENCE]       = cnt_t'(commit_i.fence | commit_i.fence_i);
    inc[core_ctrl_pkg::CNT_HALT_CYCLES] = cnt_t'(halt_i);
  end

  // ----------------------------------------------------------------------
  // Counter bank
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < core_ctrl_pkg::NR_COUNTERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < core_ctrl_pkg::NR_COUNTERS; i++) begin
        // Software write overrides the event of the same cycle
        if (perf_we_i && (perf_addr_i == core_ctrl_pkg::perf_idx_t'(i))) begin
          cnt_q[i] <= perf_wdata_i;
        end else begin
          cnt_q[i] <= cnt_q[i] + inc[i];
        end
      end
    end
  end

  // Read port
  always_comb begin
    perf_rdata_o = '0;
    for (int i = 0; i < core_ctrl_pkg::NR_COUNTERS; i++) begin
      if (perf_addr_i == core_ctrl_pkg::perf_idx_t'(i)) begin
        perf_rdata_o = cnt_q[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/core_ctrl_top.sv
// Commit control slice top; dcache ack may stall indefinitely, no other back-pressure
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_top #(
  parameter int unsigned CntWidth = core_ctrl_pkg::CNT_WIDTH_DEFAULT
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Commit stage side
  input  core_ctrl_pkg::commit_event_t commit_i,
  input  core_ctrl_pkg::redirect_ops_t redirect_ops_i,
  // Data cache
  input  logic                         dcache_flush_ack_i,
  output logic                         flush_dcache_o,
  // Pipeline control
  output core_ctrl_pkg::flush_t        flush_o,
  output logic                         halt_o,
  output core_ctrl_pkg::addr_t         redirect_pc_o,
  // Counter access port
  input  core_ctrl_pkg::perf_idx_t     perf_addr_i,
  input  logic                         perf_we_i,
  input  logic [CntWidth-1:0]          perf_wdata_i,
  output logic [CntWidth-1:0]          perf_rdata_o
);

  core_ctrl_pkg::redirect_src_t redirect_src;
  logic                         halt;

  // ----------------------------------------------------------------------
  // Controller
  // ----------------------------------------------------------------------
  flush_fsm i_flush_fsm (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .commit_i           ( commit_i           ),
    .dcache_flush_ack_i ( dcache_flush_ack_i ),
    .flush_o            ( flush_o            ),
    .flush_dcache_o     ( flush_dcache_o     ),
    .halt_o             ( halt               ),
    .redirect_src_o     ( redirect_src       )
  );

  assign halt_o = halt;

  // Next fetch address
  redirect_unit i_redirect_unit (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .redirect_src_i ( redirect_src   ),
    .redirect_ops_i ( redirect_ops_i ),
    .redirect_pc_o  ( redirect_pc_o  )
  );

  // ----------------------------------------------------------------------
  // Performance counters
  // ----------------------------------------------------------------------
  event_counters #(
    .CntWidth ( CntWidth )
  ) i_event_counters (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .halt_i       ( halt         ),
    .perf_addr_i  ( perf_addr_i  ),
    .perf_we_i    ( perf_we_i    ),
    .perf_wdata_i ( perf_wdata_i ),
    .perf_rdata_o ( perf_rdata_o )
  );

endmodule

`default_nettype wire

//--- sim/core_ctrl_checker.sv
// Flush protocol assertions, bound to core_ctrl_top; checks are disabled while reset is low
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  input core_ctrl_pkg::flush_t flush_o,
  input logic                  flush_dcache_o,
  input logic                  halt_o
);

  // ----------------------------------------------------------------------
  // Redirect shape
  // ----------------------------------------------------------------------
  a_set_pc_front: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o.set_pc |-> (flush_o.flush_if && flush_o.flush_id && flush_o.flush_ex))
    else $error("set_pc raised without flushing IF, ID and EX");

  a_icache_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o.flush_icache |-> flush_o.set_pc)
    else $error("icache flush raised without set_pc");

  // Flushes are single-cycle pulses
  a_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (flush_o != '0) |=> (flush_o == '0))
    else $error("flush_o held high for two cycles in a row");

  a_dcache_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_dcache_o |-> halt_o)
    else $error("dcache flush requested while the core is not halted");

endmodule

`default_nettype wire

//--- sim/core_ctrl_monitor.sv
// Expects one queued item per event or read record; halt-cycle reads compare against its own count
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_monitor #(
  parameter int unsigned CntWidth = core_ctrl_pkg::CNT_WIDTH_DEFAULT
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input core_ctrl_pkg::flush_t flush_o,
  input logic                  flush_dcache_o,
  input logic                  dcache_flush_ack_i,
  input logic                  halt_o,
  input core_ctrl_pkg::addr_t  redirect_pc_o,
  input logic [CntWidth-1:0]   perf_rdata_o
);

  // kind 0 redirect event, 1 fence, 2 counter read
  typedef struct packed {
    logic [1:0]  kind;
    logic [2:0]  idx;
    logic [63:0] value;
    logic [5:0]  flush;
  } expect_t;

  expect_t exp_q [$];
  int      value_errors = 0;
  int      proto_errors = 0;
  int      checks       = 0;
  int      halt_seen    = 0;

  task automatic expect_item(input logic [1:0] kind, input logic [2:0] idx,
                             input logic [63:0] value, input logic [5:0] flush);
    expect_t e;
    e.kind  = kind;
    e.idx   = idx;
    e.value = value;
    e.flush = flush;
    exp_q.push_back(e);
  endtask

  task automatic compare(input string name, input logic [63:0] expv, input logic [63:0] actv);
    checks++;
    if (actv !== expv) begin
      value_errors++;
      $display("** Error @%0t: %s expected %h, got %h", $time, name, expv, actv);
    end
  endtask

  task automatic check_quiet();
    compare("flush_o", 64'd0, 64'(flush_o));
    compare("flush_dcache_o", 64'd0, 64'(flush_dcache_o));
    compare("halt_o", 64'd0, 64'(halt_o));
    compare("redirect_pc_o", 64'd0, redirect_pc_o);
  endtask

  // Mirrors the halt-cycle counter, which counts edges with halt high
  always @(posedge clk_i) begin
    if (rst_ni && halt_o) begin
      halt_seen <= halt_seen + 1;
    end
  end

  // ----------------------------------------------------------------------
  // Reset values, during reset and the first cycle after it
  // ----------------------------------------------------------------------
  initial begin
    @(negedge clk_i);
    while (!rst_ni) begin
      check_quiet();
      @(negedge clk_i);
    end
    check_quiet();
  end

  // ----------------------------------------------------------------------
  // Expected responses, sampled on the falling edge
  // ----------------------------------------------------------------------
  initial begin
    expect_t e;
    logic    acked;
    forever begin
      wait (exp_q.size() != 0);
      e = exp_q.pop_front();
      case (e.kind)
        2'd0: begin
          repeat (2) @(negedge clk_i);
          compare("flush_o", 64'(e.flush), 64'(flush_o));
          compare("redirect_pc_o", e.value, redirect_pc_o);
        end
        2'd1: begin
          repeat (2) @(negedge clk_i);
          if (!halt_o || !flush_dcache_o) begin
            proto_errors++;
            $display("Fence at %0t did not raise halt and the dcache flush request", $time);
          end
          // Halt must fall right after the edge that samples the acknowledge
          acked = 1'b0;
          while (halt_o) begin
            if (acked) begin
              proto_errors++;
              $display("Halt still high after the dcache acknowledge at %0t", $time);
            end
            if (!flush_dcache_o || (flush_o != '0)) begin
              proto_errors++;
              $display("Dcache request dropped or pipeline flushed while halted at %0t", $time);
            end
            acked = dcache_flush_ack_i;
            @(negedge clk_i);
          end
          if (!acked) begin
            proto_errors++;
            $display("Halt dropped at %0t without a dcache acknowledge", $time);
          end
          compare("flush_o", 64'(e.flush), 64'(flush_o));
          compare("redirect_pc_o", e.value, redirect_pc_o);
        end
        default: begin
          @(negedge clk_i);
          if (e.idx == core_ctrl_pkg::CNT_HALT_CYCLES) begin
            compare("perf_rdata_o", 64'(halt_seen), 64'(perf_rdata_o));
          end else begin
            compare("perf_rdata_o", e.value, 64'(perf_rdata_o));
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_core_ctrl.sv
// Reads sim/core_ctrl_golden.txt relative to the project root; at most 128 records
`timescale 1ns/1ps
`default_nettype none

module tb_core_ctrl;

  localparam int unsigned CntWidth   = core_ctrl_pkg::CNT_WIDTH_DEFAULT;
  localparam int          MaxRecords = 128;

  logic                         clk_i;
  logic                         rst_ni;
  core_ctrl_pkg::commit_event_t commit_i;
  core_ctrl_pkg::redirect_ops_t redirect_ops_i;
  logic                         dcache_flush_ack_i;
  logic                         flush_dcache_o;
  logic                         halt_o;
  core_ctrl_pkg::flush_t        flush_o;
  core_ctrl_pkg::addr_t         redirect_pc_o;
  core_ctrl_pkg::perf_idx_t     perf_addr_i;
  logic                         perf_we_i;
  logic [CntWidth-1:0]          perf_wdata_i;
  logic [CntWidth-1:0]          perf_rdata_o;

  // Golden records
  logic [3:0]                   rec_op    [MaxRecords];
  logic [6:0]                   rec_ev    [MaxRecords];
  logic [2:0]                   rec_idx   [MaxRecords];
  logic [63:0]                  rec_data  [MaxRecords];
  core_ctrl_pkg::redirect_ops_t rec_ops   [MaxRecords];
  logic [63:0]                  rec_exp   [MaxRecords];
  logic [5:0]                   rec_flush [MaxRecords];
  int                           n_records = 0;
  logic                         loaded    = 1'b0;

  core_ctrl_top #(.CntWidth(CntWidth)) i_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .commit_i(commit_i), .redirect_ops_i(redirect_ops_i),
    .dcache_flush_ack_i(dcache_flush_ack_i), .flush_dcache_o(flush_dcache_o),
    .flush_o(flush_o), .halt_o(halt_o), .redirect_pc_o(redirect_pc_o),
    .perf_addr_i(perf_addr_i), .perf_we_i(perf_we_i), .perf_wdata_i(perf_wdata_i),
    .perf_rdata_o(perf_rdata_o)
  );

  core_ctrl_monitor #(.CntWidth(CntWidth)) i_monitor (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_o(flush_o), .flush_dcache_o(flush_dcache_o),
    .dcache_flush_ack_i(dcache_flush_ack_i),
    .halt_o(halt_o), .redirect_pc_o(redirect_pc_o), .perf_rdata_o(perf_rdata_o)
  );

  bind core_ctrl_top core_ctrl_checker i_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_o(flush_o),
    .flush_dcache_o(flush_dcache_o), .halt_o(halt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic load_golden(output bit ok);
    int          fd;
    int          code;
    int          cnt;
    string       line;
    logic [63:0] op, ev, idx, data, trap, epc, br, pcc, expv, fl;
    fd = $fopen("sim/core_ctrl_golden.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      ok = 1'b1;
      // Comment lines do not parse as ten fields and are skipped
      while (!$feof(fd) && (n_records < MaxRecords)) begin
        code = $fgets(line, fd);
        cnt  = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                       op, ev, idx, data, trap, epc, br, pcc, expv, fl);
        if ((code != 0) && (cnt == 10)) begin
          rec_op[n_records]                    = op[3:0];
          rec_ev[n_records]                    = ev[6:0];
          rec_idx[n_records]                   = idx[2:0];
          rec_data[n_records]                  = data;
          rec_ops[n_records].trap_vector       = trap;
          rec_ops[n_records].epc               = epc;
          rec_ops[n_records].branch_target     = br;
          rec_ops[n_records].pc_commit         = pcc;
          rec_exp[n_records]                   = expv;
          rec_flush[n_records]                 = fl[5:0];
          n_records++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------------------------------------
  // Record drivers
  // ----------------------------------------------------------------------
  task automatic apply_event(input int r);
    core_ctrl_pkg::commit_event_t ev;
    logic                         is_fence;
    ev       = rec_ev[r];
    is_fence = !(ev.exception || ev.eret || ev.mispredict) && (ev.fence || ev.fence_i);
    @(posedge clk_i);
    commit_i       <= ev;
    redirect_ops_i <= rec_ops[r];
    i_monitor.expect_item(is_fence ? 2'd1 : 2'd0, rec_idx[r], rec_exp[r], rec_flush[r]);
    @(posedge clk_i);
    commit_i <= '0;
    if (is_fence) begin
      // Resume redirect ends the fence
      do @(negedge clk_i); while (!flush_o.set_pc);
    end else begin
      @(posedge clk_i);
    end
  endtask

  task automatic write_counter(input int r);
    @(posedge clk_i);
    perf_we_i    <= 1'b1;
    perf_addr_i  <= rec_idx[r];
    perf_wdata_i <= rec_data[r][CntWidth-1:0];
    @(posedge clk_i);
    perf_we_i <= 1'b0;
  endtask

  task automatic read_counter(input int r);
    @(posedge clk_i);
    perf_addr_i <= rec_idx[r];
    i_monitor.expect_item(2'd2, rec_idx[r], rec_exp[r], rec_flush[r]);
    @(negedge clk_i);
  endtask

  // Dcache acknowledge after a random delay of 1 to 6 cycles
  initial begin
    int delay;
    dcache_flush_ack_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (flush_dcache_o) begin
        delay = int'($urandom_range(6, 1));
        repeat (delay - 1) @(posedge clk_i);
        dcache_flush_ack_i <= 1'b1;
        @(posedge clk_i);
        dcache_flush_ack_i <= 1'b0;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (n_records * 20 + 100) @(posedge clk_i);
    $display("Watchdog expired before all golden records were processed");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    bit file_ok;
    void'($urandom(32'hc532_ff8f));
    rst_ni         = 1'b0;
    commit_i       = '0;
    redirect_ops_i = '0;
    perf_addr_i    = '0;
    perf_we_i      = 1'b0;
    perf_wdata_i   = '0;
    load_golden(file_ok);
    if (!file_ok) begin
      $display("Cannot open the golden stimulus file");
      $display("Simulation failed");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (4) @(posedge clk_i);
      rst_ni <= 1'b1;
      for (int r = 0; r < n_records; r++) begin
        case (rec_op[r])
          4'd0:    apply_event(r);
          4'd1:    write_counter(r);
          default: read_counter(r);
        endcase
      end
      repeat (4) @(posedge clk_i);
      $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
               i_monitor.checks, i_monitor.value_errors, i_monitor.proto_errors);
      if ((i_monitor.value_errors + i_monitor.proto_errors) == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim/core_ctrl_golden.txt
# op(0 event,1 write,2 read) event(ack[6:5] exc eret mis fence fence_i) idx wdata
# trap_vector epc branch_target pc_commit expected(pc or count) expected_flush
# Exception, then priority of exception and eret over mispredict
0 30 0 0 80000100 80001234 80002000 80003000 80000100 3e
0 74 0 0 80000200 80001234 80002000 80003000 80000200 3e
0 4c 0 0 80000200 80001240 80002000 80003000 80001240 3e
# Mispredict alone, no branch predictor flush
0 24 0 0 80000200 80001240 80002100 80003000 80002100 3a
# Fence, fence.i, then both together
0 22 0 0 80000200 80001240 80002100 80003000 80003004 3a
0 61 0 0 80000200 80001240 80002100 80003010 80003014 3b
0 08 0 0 80000200 80001300 80002100 80003010 80001300 3e
0 03 0 0 80000200 80001300 80002100 80003020 80003024 3b
# Counter reads
2 00 0 0 0 0 0 0 8 0
2 00 1 0 0 0 0 0 2 0
2 00 2 0 0 0 0 0 2 0
2 00 3 0 0 0 0 0 3 0
2 00 4 0 0 0 0 0 3 0
2 00 5 0 0 0 0 0 0 0
2 00 7 0 0 0 0 0 0 0
# Write the mispredict counter, then count on from there
1 00 3 100 0 0 0 0 0 0
0 04 0 0 80000200 80001300 80002200 80003020 80002200 3a
0 04 0 0 80000200 80001300 80002210 80003020 80002210 3a
2 00 3 0 0 0 0 0 102 0
# Retired count wraps at 48 bits
1 00 0 ffffffffffff 0 0 0 0 0 0
0 64 0 0 80000200 80001300 80002300 80003020 80002300 3a
2 00 0 0 0 0 0 0 1 0
2 00 3 0 0 0 0 0 103 0
2 00 1 0 0 0 0 0 2 0
2 00 5 0 0 0 0 0 0 0
2 00 6 0 0 0 0 0 0 0

//--- files.f
logic/core_ctrl_pkg.sv
logic/flush_fsm.sv
logic/redirect_unit.sv
logic/event_counters.sv
logic/core_ctrl_top.sv
sim/core_ctrl_checker.sv
sim/core_ctrl_monitor.sv
sim/tb_core_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator from the project root; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_core_ctrl -f files.f -o tb_core_ctrl \
  && ./obj_dir/tb_core_ctrl > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
